//--- include/booth_mul_defines.svh
//************************************************
// Booth multiply cluster widths and depths
//************************************************

`ifndef BOOTH_MUL_DEFINES_SVH
`define BOOTH_MUL_DEFINES_SVH

// Operand width, must be even for radix-4 stepping
`define MUL_DATA_WIDTH 8

// Full signed product width
`define MUL_PROD_WIDTH (2 * `MUL_DATA_WIDTH)

// Tag width and result buffer depth (2 ** tag width)
`define MUL_TAG_WIDTH 3
`define MUL_BUF_DEPTH 8

// Number of multiplier peers
`define MUL_NUM_UNITS 2

`endif

//--- logic/booth_mul_pkg.sv
//************************************************
// Booth multiply cluster request and result types
//************************************************

`default_nettype none

`include "booth_mul_defines.svh"

package booth_mul_pkg;

    // Operand pair with its tag
    typedef struct packed {
        logic        [`MUL_TAG_WIDTH-1:0]  tag;
        logic signed [`MUL_DATA_WIDTH-1:0] x;
        logic signed [`MUL_DATA_WIDTH-1:0] y;
    } mul_req_t;

    // Finished product with the tag it came in with
    typedef struct packed {
        logic        [`MUL_TAG_WIDTH-1:0]  tag;
        logic signed [`MUL_PROD_WIDTH-1:0] product;
    } mul_res_t;

endpackage

`default_nettype wire

//--- logic/booth_digit_recode.sv
//************************************************
// Radix-4 Booth digit recode
// Maps a 3-bit window to 0, +-1 or +-2 times the multiplicand
//************************************************

`timescale 1ns/1ps
`default_nettype none

`include "booth_mul_defines.svh"

module booth_digit_recode (
    input  logic signed [`MUL_PROD_WIDTH-1:0] i_multiplicand,
    input  logic        [2:0]                 i_window,
    output logic signed [`MUL_PROD_WIDTH-1:0] o_partial
);

    logic signed [`MUL_PROD_WIDTH-1:0] w_mcd_x2;

    // Twice the multiplicand, MSB drops off like the product would
    assign w_mcd_x2 = i_multiplicand <<< 1;

    always_comb begin
        case (i_window)
            3'b001,
            3'b010: begin
                o_partial = i_multiplicand;
            end
            3'b011: begin
                o_partial = w_mcd_x2;
            end
            3'b100: begin
                o_partial = -w_mcd_x2;
            end
            3'b101,
            3'b110: begin
                o_partial = -i_multiplicand;
            end
            // 000 and 111 contribute nothing
            default: begin
                o_partial = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- logic/booth_seq_mul.sv
//************************************************
// Sequential radix-4 Booth multiplier
// Two multiplier bits per cycle, stops early on zero window
//************************************************

`timescale 1ns/1ps
`default_nettype none

`include "booth_mul_defines.svh"

module booth_seq_mul (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  logic                     i_start,
    input  booth_mul_pkg::mul_req_t  i_req,
    output logic                     o_busy,
    output logic                     o_done,
    output booth_mul_pkg::mul_res_t  o_res
);

    localparam int STEPS = `MUL_DATA_WIDTH / 2;
    localparam int CNT_W = $clog2(STEPS);

    logic signed [`MUL_PROD_WIDTH-1:0] r_mcd;
    logic        [`MUL_DATA_WIDTH:0]   r_mlr;
    logic signed [`MUL_PROD_WIDTH-1:0] r_acc;
    logic        [`MUL_TAG_WIDTH-1:0]  r_tag;
    logic        [CNT_W-1:0]           r_cnt;
    logic                              r_busy;
    logic                              r_done;

    logic signed [`MUL_PROD_WIDTH-1:0] w_partial;
    logic        [`MUL_DATA_WIDTH:0]   w_mlr_next;
    logic                              w_last;

    booth_digit_recode u_recode (
        .i_multiplicand (r_mcd),
        .i_window       (r_mlr[2:0]),
        .o_partial      (w_partial)
    );

    assign w_mlr_next = r_mlr >> 2;

    // Last step when the count runs out or no nonzero windows remain
    assign w_last = (r_cnt == CNT_W'(STEPS - 1)) || (w_mlr_next == '0);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            r_busy <= 1'b0;
            r_done <= 1'b0;
            r_cnt  <= '0;
        end else begin
            r_done <= 1'b0;
            if (!r_busy) begin
                if (i_start) begin
                    r_busy <= 1'b1;
                    r_cnt  <= '0;
                end
            end else begin
                r_cnt <= r_cnt + 1'b1;
                if (w_last) begin
                    r_busy <= 1'b0;
                    r_done <= 1'b1;
                end
            end
        end
    end

    // Operand and accumulator datapath
    always_ff @(posedge i_clk) begin
        if (!r_busy && i_start) begin
            r_mcd <= {{`MUL_DATA_WIDTH{i_req.x[`MUL_DATA_WIDTH-1]}}, i_req.x};
            r_mlr <= {i_req.y, 1'b0};
            r_acc <= '0;
            r_tag <= i_req.tag;
        end else if (r_busy) begin
            r_acc <= r_acc + w_partial;
            r_mcd <= r_mcd <<< 2;
            r_mlr <= w_mlr_next;
        end
    end

    assign o_busy = r_busy;
    assign o_done = r_done;

    // Accumulator holds the final product while idle
    always_comb begin
        o_res.tag     = r_tag;
        o_res.product = r_acc;
    end

    a_done_single: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_done |=> !o_done);

    a_done_after_busy: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_done |-> $past(o_busy));

endmodule

`default_nettype wire

//--- logic/result_arbiter.sv
//************************************************
// Two-way round-robin result arbiter
// One pending slot per requester, one write per cycle
//************************************************

`timescale 1ns/1ps
`default_nettype none

module result_arbiter #(
    parameter type PAYLOAD_T = booth_mul_pkg::mul_res_t
) (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic [1:0] i_req_pulse,
    input  PAYLOAD_T   i_payload [2],
    output logic       o_wr,
    output PAYLOAD_T   o_wr_payload
);

    PAYLOAD_T   r_slot [2];
    logic [1:0] r_full;
    logic       r_ptr;
    logic [1:0] w_gnt;

    // Pointer only matters when both slots wait
    always_comb begin
        case (r_full)
            2'b01:   w_gnt = 2'b01;
            2'b10:   w_gnt = 2'b10;
            2'b11:   w_gnt = r_ptr ? 2'b10 : 2'b01;
            default: w_gnt = 2'b00;
        endcase
    end

    assign o_wr         = |r_full;
    assign o_wr_payload = w_gnt[1] ? r_slot[1] : r_slot[0];

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            r_full <= 2'b00;
            r_ptr  <= 1'b0;
        end else begin
            // New pulse refills a slot even as it drains
            r_full <= (r_full & ~w_gnt) | i_req_pulse;
            if (&r_full) begin
                r_ptr <= ~r_ptr;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        for (int i = 0; i < 2; i++) begin
            if (i_req_pulse[i]) begin
                r_slot[i] <= i_payload[i];
            end
        end
    end

    for (genvar g = 0; g < 2; g++) begin : g_slot_chk
        a_no_overflow: assert property (@(posedge i_clk) disable iff (!i_rst_n)
            i_req_pulse[g] |-> (!r_full[g] || w_gnt[g]));
    end

endmodule

`default_nettype wire

//--- logic/result_buffer.sv
//************************************************
// Tag-indexed result buffer
// Valid bit per entry, combinational read, clear by tag
//************************************************

`timescale 1ns/1ps
`default_nettype none

`include "booth_mul_defines.svh"

module result_buffer (
    input  logic                              i_clk,
    input  logic                              i_rst_n,
    input  logic                              i_wr,
    input  booth_mul_pkg::mul_res_t           i_wr_res,
    input  logic        [`MUL_TAG_WIDTH-1:0]  i_rd_tag,
    input  logic                              i_rd_clr,
    output logic signed [`MUL_PROD_WIDTH-1:0] o_rd_product,
    output logic                              o_rd_valid
);

    logic signed [`MUL_PROD_WIDTH-1:0] r_mem [`MUL_BUF_DEPTH];
    logic        [`MUL_BUF_DEPTH-1:0]  r_valid;

    always_ff @(posedge i_clk) begin
        if (i_wr) begin
            r_mem[i_wr_res.tag] <= i_wr_res.product;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            r_valid <= '0;
        end else begin
            if (i_rd_clr) begin
                r_valid[i_rd_tag] <= 1'b0;
            end
            // Write comes last so it beats a clear on the same entry
            if (i_wr) begin
                r_valid[i_wr_res.tag] <= 1'b1;
            end
        end
    end

    assign o_rd_product = r_mem[i_rd_tag];
    assign o_rd_valid   = r_valid[i_rd_tag];

endmodule

`default_nettype wire

//--- logic/booth_mul_cluster.sv
//************************************************
// Booth multiply cluster top
// Two multipliers sharing one arbitrated result buffer
//************************************************

`timescale 1ns/1ps
`default_nettype none

`include "booth_mul_defines.svh"

module booth_mul_cluster (
    input  logic                              i_clk,
    input  logic                              i_rst_n,
    input  logic        [`MUL_NUM_UNITS-1:0]  i_start,
    input  booth_mul_pkg::mul_req_t           i_req [`MUL_NUM_UNITS],
    output logic        [`MUL_NUM_UNITS-1:0]  o_busy,
    input  logic        [`MUL_TAG_WIDTH-1:0]  i_rd_tag,
    input  logic                              i_rd_clr,
    output logic signed [`MUL_PROD_WIDTH-1:0] o_rd_product,
    output logic                              o_rd_valid
);

    logic [`MUL_NUM_UNITS-1:0] w_done;
    booth_mul_pkg::mul_res_t   w_res [`MUL_NUM_UNITS];
    logic                      w_wr;
    booth_mul_pkg::mul_res_t   w_wr_res;

    for (genvar u = 0; u < `MUL_NUM_UNITS; u++) begin : g_unit
        booth_seq_mul u_mul (
            .i_clk   (i_clk),
            .i_rst_n (i_rst_n),
            .i_start (i_start[u]),
            .i_req   (i_req[u]),
            .o_busy  (o_busy[u]),
            .o_done  (w_done[u]),
            .o_res   (w_res[u])
        );
    end

    result_arbiter #(
        .PAYLOAD_T (booth_mul_pkg::mul_res_t)
    ) u_arbiter (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_req_pulse  (w_done),
        .i_payload    (w_res),
        .o_wr         (w_wr),
        .o_wr_payload (w_wr_res)
    );

    result_buffer u_buffer (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_wr         (w_wr),
        .i_wr_res     (w_wr_res),
        .i_rd_tag     (i_rd_tag),
        .i_rd_clr     (i_rd_clr),
        .o_rd_product (o_rd_product),
        .o_rd_valid   (o_rd_valid)
    );

endmodule

`default_nettype wire

//--- tests/booth_mul_cluster_tb.sv
//************************************************
// Testbench for the Booth multiply cluster
// LFSR operands checked against a reference product
//************************************************

`timescale 1ns/1ps
`default_nettype none

`include "booth_mul_defines.svh"

module booth_mul_cluster_tb;

    localparam int TIMEOUT     = `MUL_DATA_WIDTH / 2 + 8;
    localparam int MIN_LAT     = 4;
    localparam int MAX_LAT     = `MUL_DATA_WIDTH / 2 + 3;
    localparam int MIN_NEG_LAT = `MUL_DATA_WIDTH / 2 + 1;

    logic                              i_clk;
    logic                              i_rst_n;
    logic        [`MUL_NUM_UNITS-1:0]  i_start;
    booth_mul_pkg::mul_req_t           i_req [`MUL_NUM_UNITS];
    logic        [`MUL_NUM_UNITS-1:0]  o_busy;
    logic        [`MUL_TAG_WIDTH-1:0]  i_rd_tag;
    logic                              i_rd_clr;
    logic signed [`MUL_PROD_WIDTH-1:0] o_rd_product;
    logic                              o_rd_valid;

    logic        [31:0]                lfsr;
    logic signed [`MUL_PROD_WIDTH-1:0] exp_prod [`MUL_BUF_DEPTH];
    logic signed [`MUL_PROD_WIDTH-1:0] chk_product;
    logic                              chk_valid;
    // Compare requests count up on chk_id and are echoed back on ack_id
    int chk_id;
    int ack_id;
    int pass_cnt;
    int fail_cnt;
    int main_pass;
    int main_fail;
    int test_base;

    booth_mul_cluster uut (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_start      (i_start),
        .i_req        (i_req),
        .o_busy       (o_busy),
        .i_rd_tag     (i_rd_tag),
        .i_rd_clr     (i_rd_clr),
        .o_rd_product (o_rd_product),
        .o_rd_valid   (o_rd_valid)
    );

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    // Galois LFSR for x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_bit();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) begin
            lfsr = lfsr ^ 32'h8020_0003;
        end
        return out;
    endfunction

    function automatic logic [`MUL_DATA_WIDTH-1:0] lfsr_byte();
        logic [`MUL_DATA_WIDTH-1:0] val;
        val = '0;
        for (int b = 0; b < `MUL_DATA_WIDTH; b++) begin
            val = {lfsr_bit(), val[`MUL_DATA_WIDTH-1:1]};
        end
        return val;
    endfunction

    // Full width signed product
    function automatic logic signed [`MUL_PROD_WIDTH-1:0] ref_product(
        input logic signed [`MUL_DATA_WIDTH-1:0] x,
        input logic signed [`MUL_DATA_WIDTH-1:0] y
    );
        logic signed [`MUL_PROD_WIDTH-1:0] wx;
        logic signed [`MUL_PROD_WIDTH-1:0] wy;
        wx = {{`MUL_DATA_WIDTH{x[`MUL_DATA_WIDTH-1]}}, x};
        wy = {{`MUL_DATA_WIDTH{y[`MUL_DATA_WIDTH-1]}}, y};
        return wx * wy;
    endfunction

    function automatic int errors();
        return fail_cnt + main_fail;
    endfunction

    // Samples the read port on the rising edge while it is stable
    always @(posedge i_clk) begin
        if (chk_id != ack_id) begin
            assert (o_rd_valid === chk_valid) pass_cnt = pass_cnt + 1;
            else begin
                $display("FAILED t=%0t o_rd_valid expected=%b actual=%b",
                         $time, chk_valid, o_rd_valid);
                fail_cnt = fail_cnt + 1;
            end
            if (chk_valid) begin
                assert (o_rd_product === chk_product) pass_cnt = pass_cnt + 1;
                else begin
                    $display("FAILED t=%0t o_rd_product expected=%0d actual=%0d",
                             $time, chk_product, o_rd_product);
                    fail_cnt = fail_cnt + 1;
                end
            end
            ack_id = chk_id;
        end
    end

    task automatic expect_entry(input logic [`MUL_TAG_WIDTH-1:0] tag, input logic valid,
                                input logic signed [`MUL_PROD_WIDTH-1:0] product);
        int n;
        i_rd_tag    = tag;
        chk_valid   = valid;
        chk_product = product;
        chk_id      = chk_id + 1;
        n = 0;
        while (ack_id != chk_id && n < TIMEOUT) begin
            @(negedge i_clk);
            n++;
        end
        if (ack_id != chk_id) begin
            $display("Timeout: compare of tag %0d was never acknowledged", tag);
            main_fail++;
        end
    endtask

    task automatic clear_tag(input logic [`MUL_TAG_WIDTH-1:0] tag);
        @(negedge i_clk);
        i_rd_tag = tag;
        i_rd_clr = 1'b1;
        @(negedge i_clk);
        i_rd_clr = 1'b0;
    endtask

    // Counts cycles on top of the caller's count until the tag turns valid
    task automatic wait_valid(input logic [`MUL_TAG_WIDTH-1:0] tag, inout int cycles);
        i_rd_tag = tag;
        #1;
        while (!o_rd_valid && cycles < TIMEOUT) begin
            @(negedge i_clk);
            cycles++;
        end
        if (!o_rd_valid) begin
            $display("Timeout: tag %0d never became valid", tag);
            main_fail++;
        end
    endtask

    task automatic run_single(input logic u, input logic [`MUL_TAG_WIDTH-1:0] tag,
                              input logic signed [`MUL_DATA_WIDTH-1:0] x,
                              input logic signed [`MUL_DATA_WIDTH-1:0] y, output int cycles);
        clear_tag(tag);
        i_req[u].tag = tag;
        i_req[u].x   = x;
        i_req[u].y   = y;
        i_start[u]   = 1'b1;
        @(negedge i_clk);
        i_start[u] = 1'b0;
        cycles = 1;
        wait_valid(tag, cycles);
        expect_entry(tag, 1'b1, ref_product(x, y));
    endtask

    // Starts an idle unit and holds start one more cycle with stray operands
    task automatic issue(input logic pref, input logic [`MUL_TAG_WIDTH-1:0] tag,
                         input logic signed [`MUL_DATA_WIDTH-1:0] x,
                         input logic signed [`MUL_DATA_WIDTH-1:0] y);
        int   n;
        logic u;
        n = 0;
        u = pref;
        while (o_busy[u] && n < TIMEOUT) begin
            if (!o_busy[!u]) begin
                u = !u;
            end else begin
                @(negedge i_clk);
                n++;
            end
        end
        if (o_busy[u]) begin
            $display("Timeout: no multiplier unit became idle for tag %0d", tag);
            main_fail++;
        end
        i_req[u].tag = tag;
        i_req[u].x   = x;
        i_req[u].y   = y;
        i_start[u]   = 1'b1;
        @(negedge i_clk);
        i_req[u].x = lfsr_byte();
        i_req[u].y = lfsr_byte();
        @(negedge i_clk);
        i_start[u] = 1'b0;
    endtask

    task automatic check_latency(input int cycles, input int lo, input int hi);
        assert (cycles >= lo && cycles <= hi) main_pass++;
        else begin
            $display("Entry turned valid after %0d cycles, allowed range is %0d to %0d",
                     cycles, lo, hi);
            main_fail++;
        end
    endtask

    task automatic report_test(input string name, input int base);
        if (errors() == base) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: %0d errors", name, errors() - base);
        end
    endtask

    initial begin
        logic signed [`MUL_DATA_WIDTH-1:0] x;
        logic signed [`MUL_DATA_WIDTH-1:0] x2;
        logic signed [`MUL_DATA_WIDTH-1:0] y;
        logic signed [`MUL_DATA_WIDTH-1:0] early_y [3];
        int early_lat [3];
        int cycles;
        int n;

        i_rst_n  = 1'b0;
        i_start  = '0;
        i_req[0] = '0;
        i_req[1] = '0;
        i_rd_tag = '0;
        i_rd_clr = 1'b0;
        lfsr     = 32'd91418;
        chk_id   = 0;
        early_y[0] = 8'sd0;
        early_y[1] = 8'sd1;
        early_y[2] = 8'sd3;
        // One Booth step for y of 0 or 1 and two steps for y of 3
        early_lat[0] = MIN_LAT;
        early_lat[1] = MIN_LAT;
        early_lat[2] = MIN_LAT + 1;
        repeat (8) @(negedge i_clk);
        i_rst_n = 1'b1;

        test_base = errors();
        assert (o_busy === '0) main_pass++;
        else begin
            $display("FAILED t=%0t o_busy expected=0 actual=%b", $time, o_busy);
            main_fail++;
        end
        for (int t = 0; t < `MUL_BUF_DEPTH; t++) begin
            expect_entry(3'(t), 1'b0, '0);
        end
        report_test("reset", test_base);

        test_base = errors();
        run_single(1'b0, 3'd0, 8'sh80, 8'sh80, cycles);
        run_single(1'b0, 3'd1, 8'sh80, 8'sh7F, cycles);
        run_single(1'b0, 3'd2, 8'sh7F, 8'sh7F, cycles);
        run_single(1'b0, 3'd3, 8'sh00, 8'shFF, cycles);
        run_single(1'b0, 3'd4, 8'shFF, 8'shFF, cycles);
        run_single(1'b0, 3'd5, 8'sh05, 8'sh00, cycles);
        report_test("corner", test_base);

        // Small multipliers stop early and negative ones run every step
        test_base = errors();
        for (int k = 0; k < 3; k++) begin
            run_single(1'b0, 3'd6, lfsr_byte(), early_y[k], cycles);
            check_latency(cycles, MIN_LAT, early_lat[k]);
            assert (o_busy[0] === 1'b0) main_pass++;
            else begin
                $display("FAILED t=%0t o_busy[0] expected=0 actual=%b", $time, o_busy[0]);
                main_fail++;
            end
        end
        run_single(1'b0, 3'd7, lfsr_byte(), 8'shFF, cycles);
        check_latency(cycles, MIN_NEG_LAT, MAX_LAT);
        run_single(1'b0, 3'd7, lfsr_byte(), 8'sh80, cycles);
        check_latency(cycles, MIN_NEG_LAT, MAX_LAT);
        report_test("early_termination", test_base);

        // Same multiplier on both units makes the done pulses collide
        test_base = errors();
        clear_tag(3'd1);
        clear_tag(3'd2);
        x  = lfsr_byte();
        x2 = lfsr_byte();
        y  = lfsr_byte();
        i_req[0].tag = 3'd1;
        i_req[0].x   = x;
        i_req[0].y   = y;
        i_req[1].tag = 3'd2;
        i_req[1].x   = x2;
        i_req[1].y   = y;
        i_start      = 2'b11;
        @(negedge i_clk);
        i_start = 2'b00;
        cycles = 1;
        wait_valid(3'd1, cycles);
        expect_entry(3'd1, 1'b1, ref_product(x, y));
        cycles = 1;
        wait_valid(3'd2, cycles);
        expect_entry(3'd2, 1'b1, ref_product(x2, y));
        report_test("simultaneous", test_base);

        test_base = errors();
        for (int batch = 0; batch < 5; batch++) begin
            for (int t = 0; t < `MUL_BUF_DEPTH; t++) begin
                clear_tag(3'(t));
            end
            for (int t = 0; t < `MUL_BUF_DEPTH; t++) begin
                x = lfsr_byte();
                y = lfsr_byte();
                exp_prod[3'(t)] = ref_product(x, y);
                n = batch * `MUL_BUF_DEPTH + t;
                issue(n[0], 3'(t), x, y);
            end
            n = 0;
            while (o_busy != '0 && n < TIMEOUT) begin
                @(negedge i_clk);
                n++;
            end
            if (o_busy != '0) begin
                $display("Timeout: units still busy at the end of batch %0d", batch);
                main_fail++;
            end
            for (int t = 0; t < `MUL_BUF_DEPTH; t++) begin
                cycles = 0;
                wait_valid(3'(t), cycles);
                expect_entry(3'(t), 1'b1, exp_prod[3'(t)]);
            end
        end
        report_test("random", test_base);

        test_base = errors();
        clear_tag(3'd3);
        for (int t = 0; t < `MUL_BUF_DEPTH; t++) begin
            expect_entry(3'(t), (t != 3), exp_prod[3'(t)]);
        end
        report_test("clear", test_base);

        $display("Checks passed: %0d, failed: %0d", pass_cnt + main_pass, errors());
        if (errors() == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- booth_mul_cluster.f
+incdir+include
logic/booth_mul_pkg.sv
logic/booth_digit_recode.sv
logic/booth_seq_mul.sv
logic/result_arbiter.sv
logic/result_buffer.sv
logic/booth_mul_cluster.sv
tests/booth_mul_cluster_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the Booth multiply cluster testbench with Verilator and runs it.
# The exit status is nonzero unless the pass line shows up in the output.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module booth_mul_cluster_tb \
    -f booth_mul_cluster.f \
    -o booth_mul_cluster_sim \
    && ./obj_dir/booth_mul_cluster_sim | tee /dev/stderr | grep "^Result: PASSED$" > /dev/null \
    && echo "Simulation run succeeded" \
    || { echo "Simulation run did not pass"; exit 1; }
